// ==== Bender.yml ====
package:
  name: btb_mem

sources:
  - files:
      - verilog/btb_pkg.sv
      - verilog/btb_sram_bank.sv
      - verilog/btb_valid_array.sv
      - verilog/btb_way_match.sv
      - verilog/btb_vbank_align.sv
      - verilog/btb_mem.sv
  - target: test
    files:
      - verif/btb_mem_assertions.sv
      - verif/btb_mem_tb.sv

// ==== build.f ====
verilog/btb_pkg.sv
verilog/btb_sram_bank.sv
verilog/btb_valid_array.sv
verilog/btb_way_match.sv
verilog/btb_vbank_align.sv
verilog/btb_mem.sv
verif/btb_mem_assertions.sv
verif/btb_mem_tb.sv

// ==== verif/btb_mem_assertions.sv ====
`timescale 1ns/10ps

module btb_mem_assertions (
   input logic                               clk,
   input logic                               rst,
   input logic                               btb_rden,
   input logic                               btb_wren,
   input logic [3:0]                         btb_wayhit_f1,
   input logic [3:0]                         btb_wayhit_p1_f1,
   input logic [btb_pkg::BTB_DWIDTH-1:0]     btb_vbank0_rd_data_f1,
   input logic [btb_pkg::BTB_DWIDTH-1:0]     btb_vbank1_rd_data_f1,
   input logic [btb_pkg::BTB_DWIDTH-1:0]     btb_vbank2_rd_data_f1,
   input logic [btb_pkg::BTB_DWIDTH-1:0]     btb_vbank3_rd_data_f1
);

   // Failed checks so far
   int fail_count = 0;

   // Read and write share the address port
   no_rw_overlap: assert property (@(posedge clk) disable iff (rst)
      !(btb_rden && btb_wren))
      else begin
         $error("Read and write strobes are high in the same cycle");
         fail_count++;
      end

   // No read in the previous cycle, so F1 outputs stay quiet
   idle_outputs_zero: assert property (@(posedge clk) disable iff (rst)
      !btb_rden |=> (btb_wayhit_f1 == '0 && btb_wayhit_p1_f1 == '0 &&
                     btb_vbank0_rd_data_f1 == '0 && btb_vbank1_rd_data_f1 == '0 &&
                     btb_vbank2_rd_data_f1 == '0 && btb_vbank3_rd_data_f1 == '0))
      else begin
         $error("Outputs are not zero in the cycle after an idle cycle");
         fail_count++;
      end

   reset_masks_zero: assert property (@(posedge clk)
      rst |=> (btb_wayhit_f1 == '0 && btb_wayhit_p1_f1 == '0))
      else begin
         $error("Hit masks are not zero after reset");
         fail_count++;
      end

endmodule

bind btb_mem btb_mem_assertions assertions_i (
   .clk                   (clk),
   .rst                   (rst),
   .btb_rden              (btb_rden),
   .btb_wren              (btb_wren),
   .btb_wayhit_f1         (btb_wayhit_f1),
   .btb_wayhit_p1_f1      (btb_wayhit_p1_f1),
   .btb_vbank0_rd_data_f1 (btb_vbank0_rd_data_f1),
   .btb_vbank1_rd_data_f1 (btb_vbank1_rd_data_f1),
   .btb_vbank2_rd_data_f1 (btb_vbank2_rd_data_f1),
   .btb_vbank3_rd_data_f1 (btb_vbank3_rd_data_f1)
);

// ==== verif/btb_mem_tb.sv ====
`timescale 1ns/10ps

module btb_mem_tb;

   localparam int DW       = btb_pkg::BTB_DWIDTH;
   localparam int OP_IDLE  = 0;
   localparam int OP_WRITE = 1;
   localparam int OP_READ  = 2;

   logic                     clk;
   logic                     rst;
   logic                     btb_rden;
   logic                     btb_wren;
   btb_pkg::btb_addr_u       btb_rw_addr;
   logic [DW-1:0]            btb_wr_data;
   logic [4:0]               btb_rd_tag;
   logic [4:0]               btb_rd_tag_p1;
   logic [DW-1:0]            btb_vbank0_rd_data_f1;
   logic [DW-1:0]            btb_vbank1_rd_data_f1;
   logic [DW-1:0]            btb_vbank2_rd_data_f1;
   logic [DW-1:0]            btb_vbank3_rd_data_f1;
   logic [3:0]               btb_wayhit_f1;
   logic [3:0]               btb_wayhit_p1_f1;

   // Stimulus table with one entry per cycle
   int                       op_q[$];
   btb_pkg::btb_addr_u       addr_q[$];
   logic [DW-1:0]            data_q[$];
   logic [4:0]               tag_q[$];
   logic [4:0]               tag_p1_q[$];
   int                       test_q[$];

   // Reference model state and expected outputs
   logic [DW-1:0]                model_mem [btb_pkg::BTB_SIZE];
   logic [btb_pkg::BTB_SIZE-1:0] model_valid;
   logic [3:0]                   exp_hit;
   logic [3:0]                   exp_hit_p1;
   logic [DW-1:0]                exp_vbank [4];

   string       test_name [1:6] = '{"reset miss", "write and hit", "miss and invalidate",
                                    "two ways one row", "bank 1 rotation", "back to back"};
   int          checks [1:6];
   int          errors [1:6];
   int          cycles = 0;
   int          cycle_limit = 0;
   logic [31:0] rng_state = 32'h289842ef;

   btb_mem dut_i (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // --------------------------------------------------
   // Table helpers
   // --------------------------------------------------

   function automatic logic [31:0] next_random();
      rng_state ^= rng_state << 13;
      rng_state ^= rng_state >> 17;
      rng_state ^= rng_state << 5;
      return rng_state;
   endfunction

   // Payload flags reuse the low offset bits
   function automatic logic [DW-1:0] make_entry(logic [4:0] tag, logic [11:0] toff,
                                                logic boff, logic pc4, logic bv);
      return {tag, toff, pc4, boff, toff[1:0], bv};
   endfunction

   function automatic logic [DW-1:0] random_entry();
      logic [31:0] r;
      r = next_random();
      return make_entry(r[4:0], r[16:5], r[17], r[18], 1'b1);
   endfunction

   function automatic btb_pkg::btb_addr_u rd_addr(logic [3:0] index, logic bank, logic [1:0] fs);
      btb_pkg::btb_addr_u a;
      a.rd.index       = index;
      a.rd.bank        = bank;
      a.rd.fetch_start = fs;
      return a;
   endfunction

   function automatic btb_pkg::btb_addr_u wr_addr(logic [3:0] index, logic bank, logic way);
      btb_pkg::btb_addr_u a;
      a.wr.index = index;
      a.wr.bank  = bank;
      a.wr.half  = 1'b0;
      a.wr.way   = way;
      return a;
   endfunction

   task automatic add_row(int test, int op, btb_pkg::btb_addr_u addr, logic [DW-1:0] data,
                          logic [4:0] tag, logic [4:0] tag_p1);
      op_q.push_back(op);
      addr_q.push_back(addr);
      data_q.push_back(data);
      tag_q.push_back(tag);
      tag_p1_q.push_back(tag_p1);
      test_q.push_back(test);
      // Two idle cycles let the valid array settle
      if (op == OP_WRITE) begin
         add_row(test, OP_IDLE, addr, '0, '0, '0);
         add_row(test, OP_IDLE, addr, '0, '0, '0);
      end
   endtask

   task automatic add_write(int test, logic [3:0] index, logic bank, logic way,
                            logic [DW-1:0] data);
      add_row(test, OP_WRITE, wr_addr(index, bank, way), data, '0, '0);
   endtask

   task automatic add_read(int test, logic [3:0] index, logic bank, logic [1:0] fs,
                           logic [4:0] tag, logic [4:0] tag_p1);
      add_row(test, OP_READ, rd_addr(index, bank, fs), '0, tag, tag_p1);
   endtask

   task automatic build_table();
      logic [DW-1:0] e0;
      logic [DW-1:0] e1;
      logic [DW-1:0] e2;
      logic [31:0]   r;
      logic [4:0]    t1;
      logic [4:0]    t2;
      add_read(1, 4'd0, 1'b0, 2'd0, 5'h00, 5'h00);
      add_read(1, 4'd5, 1'b1, 2'd3, 5'h0c, 5'h0c);
      add_read(1, 4'd15, 1'b1, 2'd2, 5'h1f, 5'h1f);
      add_write(2, 4'd3, 1'b0, 1'b0, make_entry(5'h0a, 12'h123, 1'b0, 1'b0, 1'b1));
      add_read(2, 4'd3, 1'b0, 2'd0, 5'h0a, 5'h00);
      r = next_random();
      e0 = make_entry(r[4:0], r[16:5], 1'b1, 1'b0, 1'b1);
      add_write(2, 4'd7, 1'b1, 1'b1, e0);
      add_read(2, 4'd7, 1'b1, 2'd0, e0[DW-1:btb_pkg::BTB_TAG_LSB], 5'h00);
      add_read(3, 4'd3, 1'b0, 2'd0, 5'h0b, 5'h15);
      add_write(3, 4'd3, 1'b0, 1'b0, make_entry(5'h0a, 12'h123, 1'b0, 1'b0, 1'b0));
      add_read(3, 4'd3, 1'b0, 2'd0, 5'h0a, 5'h0a);
      add_write(4, 4'd9, 1'b0, 1'b0, make_entry(5'h11, 12'h456, 1'b1, 1'b1, 1'b1));
      add_write(4, 4'd9, 1'b0, 1'b1, make_entry(5'h11, 12'h789, 1'b0, 1'b1, 1'b1));
      add_read(4, 4'd9, 1'b0, 2'd0, 5'h11, 5'h11);
      add_read(4, 4'd9, 1'b0, 2'd2, 5'h11, 5'h11);
      // Wrap from index 15 in bank 1 to index 0 in bank 0
      r = next_random();
      t1 = r[4:0];
      t2 = t1 ^ 5'h10;
      r = next_random();
      add_write(5, 4'd0, 1'b0, 1'b0, make_entry(t1, r[11:0], 1'b0, 1'b0, 1'b1));
      add_write(5, 4'd0, 1'b0, 1'b1, make_entry(t1, r[23:12], 1'b0, 1'b1, 1'b1));
      r = next_random();
      add_write(5, 4'd15, 1'b1, 1'b0, make_entry(t2, r[11:0], 1'b1, 1'b0, 1'b1));
      for (int fs = 0; fs < 4; fs++) begin
         add_read(5, 4'd15, 1'b1, 2'(fs), t2, t1);
      end
      e1 = random_entry();
      e2 = random_entry();
      add_write(5, 4'd4, 1'b1, 1'b1, e1);
      add_write(5, 4'd5, 1'b0, 1'b0, e2);
      add_read(5, 4'd4, 1'b1, 2'd1, e1[DW-1:btb_pkg::BTB_TAG_LSB], e2[DW-1:btb_pkg::BTB_TAG_LSB]);
      add_read(5, 4'd4, 1'b1, 2'd2, e1[DW-1:btb_pkg::BTB_TAG_LSB], e2[DW-1:btb_pkg::BTB_TAG_LSB]);
      add_read(6, 4'd9, 1'b0, 2'd1, 5'h11, 5'h00);
      add_read(6, 4'd15, 1'b1, 2'd3, t2, t1);
      add_read(6, 4'd7, 1'b1, 2'd2, e0[DW-1:btb_pkg::BTB_TAG_LSB], 5'h11);
      add_read(6, 4'd3, 1'b0, 2'd0, 5'h0a, 5'h0a);
      add_read(6, 4'd4, 1'b1, 2'd0, e1[DW-1:btb_pkg::BTB_TAG_LSB], e2[DW-1:btb_pkg::BTB_TAG_LSB]);
      add_row(6, OP_IDLE, '0, '0, '0, '0);
   endtask

   // --------------------------------------------------
   // Reference model
   // --------------------------------------------------

   task automatic model_write(btb_pkg::btb_addr_u a, logic [DW-1:0] d);
      int e;
      e = {a.wr.index, a.wr.bank, a.wr.way};
      if (d[btb_pkg::BV]) begin
         model_mem[e] = d;
      end
      model_valid[e] = d[btb_pkg::BV];
   endtask

   // Ways arrive as lo way0, lo way1, hi way0, hi way1
   // Slots are lo even, lo odd, hi even, hi odd
   task automatic match_pair(input logic [3:0][DW-1:0] w, input logic [3:0] v,
                             input logic [4:0] tag, output logic [3:0] hit,
                             output logic [3:0][DW-1:0] data);
      logic [DW-1:0] word;
      int            wi;
      hit  = '0;
      data = '0;
      for (int s = 0; s < 4; s++) begin
         // A slot gathers the hitting ways of its row whose branch half matches
         for (int way = 0; way < 2; way++) begin
            wi = (s < 2) ? way : 2 + way;
            word = w[wi];
            word[btb_pkg::BV] = v[wi];
            if (v[wi] && word[DW-1:btb_pkg::BTB_TAG_LSB] == tag &&
                int'(word[btb_pkg::BOFF] ^ word[btb_pkg::PC4]) == s % 2) begin
               hit[s]  = 1'b1;
               data[s] = data[s] | word;
            end
         end
      end
   endtask

   task automatic model_read(btb_pkg::btb_addr_u a, logic [4:0] tag, logic [4:0] tag_p1);
      logic [3:0][DW-1:0] w;
      logic [3:0]         v;
      logic [3:0][DW-1:0] cur;
      logic [3:0][DW-1:0] nxt;
      logic [3:0]         hi_index;
      int                 lo;
      int                 hi;
      int                 s;
      hi_index = a.rd.index + a.rd.bank;
      lo = {a.rd.index, a.rd.bank, 1'b0};
      hi = {hi_index, ~a.rd.bank, 1'b0};
      w = {model_mem[hi+1], model_mem[hi], model_mem[lo+1], model_mem[lo]};
      v = {model_valid[hi+1], model_valid[hi], model_valid[lo+1], model_valid[lo]};
      match_pair(w, v, tag, exp_hit, cur);
      // Next pair starts with the hi row
      match_pair({w[1:0], w[3:2]}, {v[1:0], v[3:2]}, tag_p1, exp_hit_p1, nxt);
      for (int k = 0; k < 4; k++) begin
         s = int'(a.rd.fetch_start) + k;
         exp_vbank[k] = (s < 4) ? cur[s] : nxt[s-4];
      end
   endtask

   // --------------------------------------------------
   // Checks
   // --------------------------------------------------

   task automatic check_value(string name, logic [DW-1:0] got, logic [DW-1:0] exp,
                              int test, int row);
      checks[test]++;
      assert (got === exp) else begin
         $display("FAIL row %0d %s got %0h expected %0h", row, name, got, exp);
         errors[test]++;
      end
   endtask

   task automatic check_row(int row);
      int t;
      t = test_q[row];
      check_value("btb_wayhit_f1", btb_wayhit_f1, exp_hit, t, row);
      check_value("btb_wayhit_p1_f1", btb_wayhit_p1_f1, exp_hit_p1, t, row);
      check_value("btb_vbank0_rd_data_f1", btb_vbank0_rd_data_f1, exp_vbank[0], t, row);
      check_value("btb_vbank1_rd_data_f1", btb_vbank1_rd_data_f1, exp_vbank[1], t, row);
      check_value("btb_vbank2_rd_data_f1", btb_vbank2_rd_data_f1, exp_vbank[2], t, row);
      check_value("btb_vbank3_rd_data_f1", btb_vbank3_rd_data_f1, exp_vbank[3], t, row);
   endtask

   // --------------------------------------------------
   // Main sequence
   // --------------------------------------------------

   initial begin
      int n;
      int total_checks;
      int total_errors;
      rst           = 1'b1;
      btb_rden      = 1'b0;
      btb_wren      = 1'b0;
      btb_rw_addr   = '0;
      btb_wr_data   = '0;
      btb_rd_tag    = '0;
      btb_rd_tag_p1 = '0;
      model_valid   = '0;
      build_table();
      n = op_q.size();
      cycle_limit = n * 2 + 50;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      for (int i = 0; i <= n; i++) begin
         @(posedge clk);
         // Tags belong to the read of the previous cycle
         if (i > 0 && op_q[i-1] == OP_READ) begin
            btb_rd_tag    <= tag_q[i-1];
            btb_rd_tag_p1 <= tag_p1_q[i-1];
         end else begin
            btb_rd_tag    <= '0;
            btb_rd_tag_p1 <= '0;
         end
         btb_rden <= (i < n) && (op_q[i] == OP_READ);
         btb_wren <= (i < n) && (op_q[i] == OP_WRITE);
         if (i < n) begin
            btb_rw_addr <= addr_q[i];
            btb_wr_data <= data_q[i];
         end
         @(negedge clk);
         if (i > 0) begin
            check_row(i - 1);
            if (i == n || test_q[i] != test_q[i-1]) begin
               $display("Test %0d (%s) done: %0d checks, %0d errors", test_q[i-1],
                        test_name[test_q[i-1]], checks[test_q[i-1]], errors[test_q[i-1]]);
            end
         end
         if (i < n) begin
            exp_hit    = '0;
            exp_hit_p1 = '0;
            exp_vbank  = '{default: '0};
            if (op_q[i] == OP_READ) begin
               model_read(addr_q[i], tag_q[i], tag_p1_q[i]);
            end else if (op_q[i] == OP_WRITE) begin
               model_write(addr_q[i], data_q[i]);
            end
         end
      end
      total_checks = checks.sum();
      total_errors = errors.sum() + dut_i.assertions_i.fail_count;
      $display("Checks: %0d, errors: %0d", total_checks, total_errors);
      if (total_errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

   // Watchdog on the whole run
   initial begin
      wait (cycle_limit > 0);
      while (cycles <= cycle_limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: the stimulus table did not finish within %0d cycles", cycle_limit);
      $display("Finished with errors");
      $finish;
   end

endmodule

// ==== verilog/btb_mem.sv ====
`timescale 1ns/10ps

module btb_mem (
   input  logic                                 clk,
   input  logic                                 rst,
   input  logic                                 btb_rden,
   input  logic                                 btb_wren,
   input  btb_pkg::btb_addr_u                   btb_rw_addr,
   input  logic [btb_pkg::BTB_DWIDTH-1:0]       btb_wr_data,
   input  logic [btb_pkg::BTB_BTAG_SIZE-1:0]    btb_rd_tag,
   input  logic [btb_pkg::BTB_BTAG_SIZE-1:0]    btb_rd_tag_p1,
   output logic [btb_pkg::BTB_DWIDTH-1:0]       btb_vbank0_rd_data_f1,
   output logic [btb_pkg::BTB_DWIDTH-1:0]       btb_vbank1_rd_data_f1,
   output logic [btb_pkg::BTB_DWIDTH-1:0]       btb_vbank2_rd_data_f1,
   output logic [btb_pkg::BTB_DWIDTH-1:0]       btb_vbank3_rd_data_f1,
   output logic [3:0]                           btb_wayhit_f1,
   output logic [3:0]                           btb_wayhit_p1_f1
);

   logic                                    btb_rden_f1;
   btb_pkg::btb_addr_u                      btb_rd_addr_f1;

   logic [1:0]                              bank_we;
   logic [1:0]                              bank_en;
   logic [btb_pkg::BTB_INDEX_W-1:0]         rd_index_p1;
   logic [btb_pkg::BTB_INDEX_W-1:0]         bank0_index;
   logic [btb_pkg::BTB_INDEX_W-1:0]         bank1_index;
   logic [btb_pkg::BTB_INDEX_W-1:0]         hi_index_f1;

   logic [2*btb_pkg::BTB_DWIDTH-1:0]        bank0_rd_data;
   logic [2*btb_pkg::BTB_DWIDTH-1:0]        bank1_rd_data;
   logic [2*btb_pkg::BTB_DWIDTH-1:0]        lo_row_f1;
   logic [2*btb_pkg::BTB_DWIDTH-1:0]        hi_row_f1;

   logic [3:0]                              valid_f1;
   logic [3:0][btb_pkg::BTB_DWIDTH-1:0]     cur_slot_data;
   logic [3:0][btb_pkg::BTB_DWIDTH-1:0]     next_slot_data;

   // --------------------------------------------------
   // Bank index and write steering
   // --------------------------------------------------

   assign rd_index_p1 = btb_rw_addr.rd.index +
                        {{(btb_pkg::BTB_INDEX_W-1){1'b0}}, btb_rw_addr.rd.bank};

   // Bank 0 is the hi row when the fetch starts in bank 1
   assign bank0_index = btb_wren ? btb_rw_addr.wr.index : rd_index_p1;
   // Bank 1 never takes the incremented index, and both views share the index bits
   assign bank1_index = btb_rw_addr.rd.index;

   // Invalidates only touch the valid array
   assign bank_we[0] = btb_wren & ~btb_rw_addr.wr.bank & btb_wr_data[btb_pkg::BV];
   assign bank_we[1] = btb_wren & btb_rw_addr.wr.bank & btb_wr_data[btb_pkg::BV];
   assign bank_en    = {2{btb_rden}} | bank_we;

   btb_sram_bank bank0_i (
      .clk     (clk),
      .en      (bank_en[0]),
      .we      (bank_we[0]),
      .way     (btb_rw_addr.wr.way),
      .index   (bank0_index),
      .wr_data (btb_wr_data),
      .rd_data (bank0_rd_data)
   );

   btb_sram_bank bank1_i (
      .clk     (clk),
      .en      (bank_en[1]),
      .we      (bank_we[1]),
      .way     (btb_rw_addr.wr.way),
      .index   (bank1_index),
      .wr_data (btb_wr_data),
      .rd_data (bank1_rd_data)
   );

   // --------------------------------------------------
   // F1 stage
   // --------------------------------------------------

   always_ff @(posedge clk) begin
      if (rst) begin
         btb_rden_f1 <= 1'b0;
      end else begin
         btb_rden_f1 <= btb_rden;
      end
   end

   always_ff @(posedge clk) begin
      if (btb_rden) begin
         btb_rd_addr_f1 <= btb_rw_addr;
      end
   end

   assign hi_index_f1 = btb_rd_addr_f1.rd.index +
                        {{(btb_pkg::BTB_INDEX_W-1){1'b0}}, btb_rd_addr_f1.rd.bank};

   btb_valid_array valid_i (
      .clk      (clk),
      .rst      (rst),
      .wren     (btb_wren),
      .wr_addr  (btb_rw_addr),
      .wr_valid (btb_wr_data[btb_pkg::BV]),
      .lo_index (btb_rd_addr_f1.rd.index),
      .hi_index (hi_index_f1),
      .lo_bank  (btb_rd_addr_f1.rd.bank),
      .valid_f1 (valid_f1)
   );

   // Lo row comes from the bank the fetch starts in
   assign lo_row_f1 = btb_rd_addr_f1.rd.bank ? bank1_rd_data : bank0_rd_data;
   assign hi_row_f1 = btb_rd_addr_f1.rd.bank ? bank0_rd_data : bank1_rd_data;

   btb_way_match cur_match_i (
      .rden_f1   (btb_rden_f1),
      .lo_row    (lo_row_f1),
      .hi_row    (hi_row_f1),
      .valid     (valid_f1),
      .tag       (btb_rd_tag),
      .slot_hit  (btb_wayhit_f1),
      .slot_data (cur_slot_data)
   );

   // Next pair sees the rows swapped
   btb_way_match next_match_i (
      .rden_f1   (btb_rden_f1),
      .lo_row    (hi_row_f1),
      .hi_row    (lo_row_f1),
      .valid     ({valid_f1[1:0], valid_f1[3:2]}),
      .tag       (btb_rd_tag_p1),
      .slot_hit  (btb_wayhit_p1_f1),
      .slot_data (next_slot_data)
   );

   btb_vbank_align align_i (
      .fetch_start (btb_rd_addr_f1.rd.fetch_start),
      .cur_data    (cur_slot_data),
      .next_data   (next_slot_data[2:0]),
      .vbank0_data (btb_vbank0_rd_data_f1),
      .vbank1_data (btb_vbank1_rd_data_f1),
      .vbank2_data (btb_vbank2_rd_data_f1),
      .vbank3_data (btb_vbank3_rd_data_f1)
   );

endmodule

// ==== verilog/btb_pkg.sv ====
package btb_pkg;

   // --------------------------------------------------
   // Sizes
   // --------------------------------------------------

   // Entry address runs from bit 7 down to bit 1
   localparam int BTB_ADDR_HI      = 7;
   // Bits above the bank bit form the row index
   localparam int BTB_INDEX_W      = BTB_ADDR_HI - 3;
   localparam int BTB_ROWS         = 1 << BTB_INDEX_W;
   // Rows x 2 banks x 2 ways
   localparam int BTB_SIZE         = BTB_ROWS * 4;

   // --------------------------------------------------
   // Entry layout
   // --------------------------------------------------

   localparam int BTB_BTAG_SIZE    = 5;
   localparam int BTB_TOFFSET_SIZE = 12;
   // Tag, target offset and 5 flag bits
   localparam int BTB_DWIDTH       = BTB_TOFFSET_SIZE + BTB_BTAG_SIZE + 5;
   // Tag sits in the top bits of the entry
   localparam int BTB_TAG_LSB      = BTB_DWIDTH - BTB_BTAG_SIZE;

   // Flag positions
   // Bits 1 and 2 are payload only
   localparam int BV               = 0;
   localparam int BOFF             = 3;
   localparam int PC4              = 4;

   // Fetch address on reads, entry address on writes
   typedef union packed {
      struct packed {
         logic [BTB_INDEX_W-1:0] index;
         logic                   bank;
         // Halfword where the fetch begins
         logic [1:0]             fetch_start;
      } rd;
      struct packed {
         logic [BTB_INDEX_W-1:0] index;
         logic                   bank;
         // Unused in this array size
         logic                   half;
         logic                   way;
      } wr;
   } btb_addr_u;

endpackage

// ==== verilog/btb_sram_bank.sv ====
`timescale 1ns/10ps

module btb_sram_bank (
   input  logic                                 clk,
   input  logic                                 en,
   input  logic                                 we,
   input  logic                                 way,
   input  logic [btb_pkg::BTB_INDEX_W-1:0]      index,
   input  logic [btb_pkg::BTB_DWIDTH-1:0]       wr_data,
   output logic [2*btb_pkg::BTB_DWIDTH-1:0]     rd_data
);

   // Way 0 in the low half of a row, way 1 in the high half
   logic [2*btb_pkg::BTB_DWIDTH-1:0] row_mem [0:btb_pkg::BTB_ROWS-1];
   logic [1:0]                       way_we;

   // Per-way write enable
   assign way_we = {we & way, we & ~way};

   // --------------------------------------------------
   // Row access
   // --------------------------------------------------

   always_ff @(posedge clk) begin
      if (en) begin
         if (we) begin
            if (way_we[0]) begin
               row_mem[index][btb_pkg::BTB_DWIDTH-1:0] <= wr_data;
            end
            if (way_we[1]) begin
               row_mem[index][2*btb_pkg::BTB_DWIDTH-1:btb_pkg::BTB_DWIDTH] <= wr_data;
            end
         end else begin
            // Whole row with both ways side by side
            rd_data <= row_mem[index];
         end
      end
   end

endmodule

// ==== verilog/btb_valid_array.sv ====
`timescale 1ns/10ps

module btb_valid_array (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              wren,
   input  btb_pkg::btb_addr_u                wr_addr,
   input  logic                              wr_valid,
   input  logic [btb_pkg::BTB_INDEX_W-1:0]   lo_index,
   input  logic [btb_pkg::BTB_INDEX_W-1:0]   hi_index,
   input  logic                              lo_bank,
   output logic [3:0]                        valid_f1
);

   logic                          wren_f1;
   btb_pkg::btb_addr_u            wr_addr_f1;
   logic                          wr_valid_f1;
   logic [btb_pkg::BTB_SIZE-1:0]  btb_valid;

   // --------------------------------------------------
   // Write stage
   // --------------------------------------------------

   always_ff @(posedge clk) begin
      if (rst) begin
         wren_f1 <= 1'b0;
      end else begin
         wren_f1 <= wren;
      end
   end

   always_ff @(posedge clk) begin
      if (wren) begin
         wr_addr_f1  <= wr_addr;
         wr_valid_f1 <= wr_valid;
      end
   end

   // Entry number is {index, bank, way}
   always_ff @(posedge clk) begin
      if (rst) begin
         btb_valid <= '0;
      end else if (wren_f1) begin
         btb_valid[{wr_addr_f1.wr.index, wr_addr_f1.wr.bank, wr_addr_f1.wr.way}] <= wr_valid_f1;
      end
   end

   // --------------------------------------------------
   // Read of the two fetch rows
   // --------------------------------------------------

   // The hi row always lives in the other bank
   assign valid_f1[0] = btb_valid[{lo_index, lo_bank, 1'b0}];
   assign valid_f1[1] = btb_valid[{lo_index, lo_bank, 1'b1}];
   assign valid_f1[2] = btb_valid[{hi_index, ~lo_bank, 1'b0}];
   assign valid_f1[3] = btb_valid[{hi_index, ~lo_bank, 1'b1}];

endmodule

// ==== verilog/btb_vbank_align.sv ====
`timescale 1ns/10ps

module btb_vbank_align (
   input  logic [1:0]                              fetch_start,
   input  logic [3:0][btb_pkg::BTB_DWIDTH-1:0]     cur_data,
   input  logic [2:0][btb_pkg::BTB_DWIDTH-1:0]     next_data,
   output logic [btb_pkg::BTB_DWIDTH-1:0]          vbank0_data,
   output logic [btb_pkg::BTB_DWIDTH-1:0]          vbank1_data,
   output logic [btb_pkg::BTB_DWIDTH-1:0]          vbank2_data,
   output logic [btb_pkg::BTB_DWIDTH-1:0]          vbank3_data
);

   // Virtual bank k takes slot fetch_start+k, spilling into the next pair
   always_comb begin
      case (fetch_start)
         2'd0: begin
            vbank0_data = cur_data[0];
            vbank1_data = cur_data[1];
            vbank2_data = cur_data[2];
            vbank3_data = cur_data[3];
         end
         2'd1: begin
            vbank0_data = cur_data[1];
            vbank1_data = cur_data[2];
            vbank2_data = cur_data[3];
            vbank3_data = next_data[0];
         end
         2'd2: begin
            vbank0_data = cur_data[2];
            vbank1_data = cur_data[3];
            vbank2_data = next_data[0];
            vbank3_data = next_data[1];
         end
         default: begin
            // A start in the last halfword takes three slots from the next pair
            vbank0_data = cur_data[3];
            vbank1_data = next_data[0];
            vbank2_data = next_data[1];
            vbank3_data = next_data[2];
         end
      endcase
   end

endmodule

// ==== verilog/btb_way_match.sv ====
`timescale 1ns/10ps

module btb_way_match (
   input  logic                                    rden_f1,
   input  logic [2*btb_pkg::BTB_DWIDTH-1:0]        lo_row,
   input  logic [2*btb_pkg::BTB_DWIDTH-1:0]        hi_row,
   input  logic [3:0]                              valid,
   input  logic [btb_pkg::BTB_BTAG_SIZE-1:0]       tag,
   output logic [3:0]                              slot_hit,
   output logic [3:0][btb_pkg::BTB_DWIDTH-1:0]     slot_data
);

   // Way order is lo way0, lo way1, hi way0, hi way1
   logic [3:0][btb_pkg::BTB_DWIDTH-1:0] way_word;
   logic [3:0]                          way_hit;
   logic [3:0]                          way_odd;

   // --------------------------------------------------
   // Way words with the valid array bit
   // --------------------------------------------------

   always_comb begin
      way_word[0] = lo_row[btb_pkg::BTB_DWIDTH-1:0];
      way_word[1] = lo_row[2*btb_pkg::BTB_DWIDTH-1:btb_pkg::BTB_DWIDTH];
      way_word[2] = hi_row[btb_pkg::BTB_DWIDTH-1:0];
      way_word[3] = hi_row[2*btb_pkg::BTB_DWIDTH-1:btb_pkg::BTB_DWIDTH];
      // SRAM copy of BV is stale after an invalidate
      for (int i = 0; i < 4; i++) begin
         way_word[i][btb_pkg::BV] = valid[i];
      end
   end

   // --------------------------------------------------
   // Tag compare
   // --------------------------------------------------

   always_comb begin
      for (int i = 0; i < 4; i++) begin
         way_hit[i] = rden_f1 & way_word[i][btb_pkg::BV] &
                      (way_word[i][btb_pkg::BTB_DWIDTH-1:btb_pkg::BTB_TAG_LSB] == tag);
         // Branch in the second halfword of its pair
         way_odd[i] = way_word[i][btb_pkg::BOFF] ^ way_word[i][btb_pkg::PC4];
      end
   end

   // --------------------------------------------------
   // Slot ordering
   // --------------------------------------------------

   // Row r owns slots 2r (even) and 2r+1 (odd)
   always_comb begin
      int s;
      slot_hit  = '0;
      slot_data = '0;
      for (int i = 0; i < 4; i++) begin
         s = 2 * (i / 2) + int'(way_odd[i]);
         if (way_hit[i]) begin
            slot_hit[s]  = 1'b1;
            slot_data[s] = slot_data[s] | way_word[i];
         end
      end
   end

endmodule
